//--- logic/bridge_pkg.sv
// ------------------------------
// Bridge package
// Bus widths, request and response structs and state encodings
// for the core to Wishbone bridge
// ------------------------------
package bridge_pkg;

    localparam int unsigned ADDR_W             = 32;
    localparam int unsigned DATA_W             = 32;
    localparam int unsigned SEL_W              = 4;
    localparam int unsigned TIMEOUT_CYCLES_DEF = 16;

    // ------------------------------
    // Core side
    // ------------------------------
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
    } fetch_req_t;

    typedef struct packed {
        logic              we;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
        logic [SEL_W-1:0]  sel;
    } lsu_req_t;

    // Reply to either port
    typedef struct packed {
        logic [DATA_W-1:0] rdata;
        logic              err;
    } port_rsp_t;

    // ------------------------------
    // Wishbone classic
    // ------------------------------
    typedef struct packed {
        logic              cyc;
        logic              stb;
        logic              we;
        logic [ADDR_W-1:0] adr;
        logic [DATA_W-1:0] dat;
        logic [SEL_W-1:0]  sel;
    } wb_m2s_t;

    typedef struct packed {
        logic              ack;
        logic              err;
        logic [DATA_W-1:0] dat;
    } wb_s2m_t;

    typedef enum logic [1:0] {
        CYC_IDLE  = 2'd0,
        CYC_FETCH = 2'd1,
        CYC_LSU   = 2'd2,
        CYC_DONE  = 2'd3
    } cyc_state_e;

    typedef enum logic {
        PORT_FETCH = 1'b0,
        PORT_LSU   = 1'b1
    } port_sel_e;

endpackage

//--- logic/fetch_port.sv
`timescale 1ns/1ps
// ------------------------------
// Fetch port
// Registers the core fetch pulse and tracks the outstanding fetch
// ------------------------------
module fetch_port (
     input  logic                   clk_i
    ,input  logic                   rst_ni
    ,input  logic                   fetch_valid_i
    ,input  bridge_pkg::fetch_req_t fetch_req_i
    ,input  logic                   take_i
    ,input  logic                   done_i
    ,input  bridge_pkg::port_rsp_t  rsp_i
    ,output logic                   req_valid_o
    ,output bridge_pkg::fetch_req_t req_o
    ,output logic                   fetch_ack_o
    ,output bridge_pkg::port_rsp_t  fetch_rsp_o
);

    import bridge_pkg::*;

    logic       valid_q;
    logic       pending_q;
    logic       capture;
    fetch_req_t req_q;

    // A pulse counts only when nothing is queued or on the bus
    assign capture = fetch_valid_i & ~valid_q & ~pending_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= 1'b0;
        end else if (take_i) begin
            valid_q <= 1'b0;
        end else if (capture) begin
            valid_q <= 1'b1;
        end
    end

    // Request register, breaks the path from the core fetch stage
    always_ff @(posedge clk_i) begin
        if (capture) begin
            req_q <= fetch_req_i;
        end
    end

    // Outstanding from the grant until the reply comes back
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            pending_q <= 1'b0;
        end else if (take_i) begin
            pending_q <= 1'b1;
        end else if (done_i) begin
            pending_q <= 1'b0;
        end
    end

    assign req_valid_o = valid_q;
    assign req_o       = req_q;
    assign fetch_ack_o = done_i;
    assign fetch_rsp_o = rsp_i;

endmodule

//--- logic/lsu_port.sv
`timescale 1ns/1ps
// ------------------------------
// Load/store port
// Gates the held core request while one is in flight
// and returns the reply with a one-cycle ack
// ------------------------------
module lsu_port (
     input  logic                  clk_i
    ,input  logic                  rst_ni
    ,input  logic                  lsu_valid_i
    ,input  bridge_pkg::lsu_req_t  lsu_req_i
    ,input  logic                  take_i
    ,input  logic                  done_i
    ,input  bridge_pkg::port_rsp_t rsp_i
    ,output logic                  req_valid_o
    ,output bridge_pkg::lsu_req_t  req_o
    ,output logic                  lsu_ack_o
    ,output bridge_pkg::port_rsp_t lsu_rsp_o
);

    import bridge_pkg::*;

    logic      pending_q;
    port_rsp_t rsp_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            pending_q <= 1'b0;
        end else if (take_i) begin
            pending_q <= 1'b1;
        end else if (done_i) begin
            pending_q <= 1'b0;
        end
    end

    // Core holds valid until ack, so hide it once granted
    assign req_valid_o = lsu_valid_i & ~pending_q;
    assign req_o       = lsu_req_i;

    // Last load/store reply stays readable while fetches reuse the bus
    always_ff @(posedge clk_i) begin
        if (done_i) begin
            rsp_q <= rsp_i;
        end
    end

    assign lsu_ack_o = done_i;
    assign lsu_rsp_o = done_i ? rsp_i : rsp_q;

endmodule

//--- logic/bus_cycle_fsm.sv
`timescale 1ns/1ps
// ------------------------------
// Bus cycle FSM
// Arbitrates fetch and load/store requests and runs one
// Wishbone classic cycle at a time
// ------------------------------
module bus_cycle_fsm (
     input  logic                   clk_i
    ,input  logic                   rst_ni
    ,input  logic                   fetch_valid_i
    ,input  bridge_pkg::fetch_req_t fetch_req_i
    ,input  logic                   lsu_valid_i
    ,input  bridge_pkg::lsu_req_t   lsu_req_i
    ,input  bridge_pkg::wb_s2m_t    wb_i
    ,input  logic                   timeout_i
    ,output logic                   fetch_take_o
    ,output logic                   lsu_take_o
    ,output logic                   fetch_done_o
    ,output logic                   lsu_done_o
    ,output bridge_pkg::port_rsp_t  rsp_o
    ,output bridge_pkg::wb_m2s_t    wb_o
    ,output logic                   watch_run_o
);

    import bridge_pkg::*;

    cyc_state_e state_q;
    cyc_state_e state_d;
    port_sel_e  owner_q;
    logic       cyc_q;
    lsu_req_t   bus_req_q;
    lsu_req_t   fetch_as_req;
    port_rsp_t  rsp_q;
    logic       grant_fetch;
    logic       grant_lsu;
    logic       bus_end;

    // ------------------------------
    // Arbitration
    // ------------------------------
    // On a tie the port that did not own the last cycle wins
    assign grant_fetch  = fetch_valid_i & (~lsu_valid_i | (owner_q == PORT_LSU));
    assign grant_lsu    = lsu_valid_i & ~grant_fetch;
    assign fetch_take_o = (state_q == CYC_IDLE) & grant_fetch;
    assign lsu_take_o   = (state_q == CYC_IDLE) & grant_lsu;

    // Fetch is a full-word read
    always_comb begin
        fetch_as_req      = '0;
        fetch_as_req.addr = fetch_req_i.addr;
        fetch_as_req.sel  = '1;
    end

    // Watchdog expiry closes the cycle like a slave error
    assign bus_end = wb_i.ack | wb_i.err | timeout_i;

    always_comb begin
        state_d = state_q;
        case (state_q)
            CYC_IDLE: begin
                if (grant_fetch) begin
                    state_d = CYC_FETCH;
                end else if (grant_lsu) begin
                    state_d = CYC_LSU;
                end
            end
            CYC_FETCH, CYC_LSU: begin
                if (bus_end) begin
                    state_d = CYC_DONE;
                end
            end
            default: state_d = CYC_IDLE;
        endcase
    end

    // ------------------------------
    // Registers
    // ------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= CYC_IDLE;
            owner_q <= PORT_LSU;
            cyc_q   <= 1'b0;
        end else begin
            state_q <= state_d;
            if (fetch_take_o) begin
                owner_q <= PORT_FETCH;
                cyc_q   <= 1'b1;
            end else if (lsu_take_o) begin
                owner_q <= PORT_LSU;
                cyc_q   <= 1'b1;
            end else if (cyc_q && bus_end) begin
                cyc_q <= 1'b0;
            end
        end
    end

    // Address, data, we and sel held for the whole cycle
    always_ff @(posedge clk_i) begin
        if (fetch_take_o) begin
            bus_req_q <= fetch_as_req;
        end else if (lsu_take_o) begin
            bus_req_q <= lsu_req_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (cyc_q && bus_end) begin
            rsp_q.rdata <= (wb_i.ack && !wb_i.err) ? wb_i.dat : '0;
            rsp_q.err   <= wb_i.err | (timeout_i & ~wb_i.ack);
        end
    end

    // ------------------------------
    // Outputs
    // ------------------------------
    assign fetch_done_o = (state_q == CYC_DONE) & (owner_q == PORT_FETCH);
    assign lsu_done_o   = (state_q == CYC_DONE) & (owner_q == PORT_LSU);
    assign rsp_o        = rsp_q;
    assign watch_run_o  = cyc_q;

    always_comb begin
        wb_o.cyc = cyc_q;
        wb_o.stb = cyc_q;
        wb_o.we  = bus_req_q.we;
        wb_o.adr = bus_req_q.addr;
        wb_o.dat = bus_req_q.wdata;
        wb_o.sel = bus_req_q.sel;
    end

endmodule

//--- logic/bus_watchdog.sv
`timescale 1ns/1ps
// ------------------------------
// Bus watchdog
// Flags a bus cycle that stays open for TIMEOUT_CYCLES edges
// ------------------------------
module bus_watchdog #(
    parameter int unsigned TIMEOUT_CYCLES = bridge_pkg::TIMEOUT_CYCLES_DEF
) (
     input  logic clk_i
    ,input  logic rst_ni
    ,input  logic run_i
    ,output logic timeout_o
);

    localparam int unsigned      CNT_W = $clog2(TIMEOUT_CYCLES + 1);
    localparam logic [CNT_W-1:0] LAST  = CNT_W'(TIMEOUT_CYCLES - 1);

    logic [CNT_W-1:0] cnt_q;

    // Edges seen with the cycle open, saturating at the limit
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            cnt_q <= '0;
        end else if (!run_i) begin
            cnt_q <= '0;
        end else if (cnt_q != LAST) begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    // The closing edge of this cycle is the limit-th one
    assign timeout_o = run_i & (cnt_q == LAST);

endmodule

//--- logic/core_bus_bridge.sv
`timescale 1ns/1ps
// ------------------------------
// Core bus bridge
// Merges the fetch and load/store ports onto one
// Wishbone classic master with a bus watchdog
// ------------------------------
module core_bus_bridge #(
    parameter int unsigned TIMEOUT_CYCLES = bridge_pkg::TIMEOUT_CYCLES_DEF
) (
     input  logic                   clk_i
    ,input  logic                   rst_ni
    ,input  logic                   fetch_valid_i
    ,input  bridge_pkg::fetch_req_t fetch_req_i
    ,input  logic                   lsu_valid_i
    ,input  bridge_pkg::lsu_req_t   lsu_req_i
    ,input  bridge_pkg::wb_s2m_t    wb_i
    ,output logic                   fetch_ack_o
    ,output bridge_pkg::port_rsp_t  fetch_rsp_o
    ,output logic                   lsu_ack_o
    ,output bridge_pkg::port_rsp_t  lsu_rsp_o
    ,output bridge_pkg::wb_m2s_t    wb_o
);

    import bridge_pkg::*;

    logic       fetch_valid;
    fetch_req_t fetch_req;
    logic       lsu_valid;
    lsu_req_t   lsu_req;
    logic       fetch_take;
    logic       lsu_take;
    logic       fetch_done;
    logic       lsu_done;
    port_rsp_t  bus_rsp;
    logic       watch_run;
    logic       timeout;

    // ------------------------------
    // Core ports
    // ------------------------------
    fetch_port u_fetch_port (
         .clk_i         ( clk_i         )
        ,.rst_ni        ( rst_ni        )
        ,.fetch_valid_i ( fetch_valid_i )
        ,.fetch_req_i   ( fetch_req_i   )
        ,.take_i        ( fetch_take    )
        ,.done_i        ( fetch_done    )
        ,.rsp_i         ( bus_rsp       )
        ,.req_valid_o   ( fetch_valid   )
        ,.req_o         ( fetch_req     )
        ,.fetch_ack_o   ( fetch_ack_o   )
        ,.fetch_rsp_o   ( fetch_rsp_o   )
    );

    lsu_port u_lsu_port (
         .clk_i       ( clk_i       )
        ,.rst_ni      ( rst_ni      )
        ,.lsu_valid_i ( lsu_valid_i )
        ,.lsu_req_i   ( lsu_req_i   )
        ,.take_i      ( lsu_take    )
        ,.done_i      ( lsu_done    )
        ,.rsp_i       ( bus_rsp     )
        ,.req_valid_o ( lsu_valid   )
        ,.req_o       ( lsu_req     )
        ,.lsu_ack_o   ( lsu_ack_o   )
        ,.lsu_rsp_o   ( lsu_rsp_o   )
    );

    // ------------------------------
    // Bus side
    // ------------------------------
    bus_cycle_fsm u_bus_cycle_fsm (
         .clk_i         ( clk_i       )
        ,.rst_ni        ( rst_ni      )
        ,.fetch_valid_i ( fetch_valid )
        ,.fetch_req_i   ( fetch_req   )
        ,.lsu_valid_i   ( lsu_valid   )
        ,.lsu_req_i     ( lsu_req     )
        ,.wb_i          ( wb_i        )
        ,.timeout_i     ( timeout     )
        ,.fetch_take_o  ( fetch_take  )
        ,.lsu_take_o    ( lsu_take    )
        ,.fetch_done_o  ( fetch_done  )
        ,.lsu_done_o    ( lsu_done    )
        ,.rsp_o         ( bus_rsp     )
        ,.wb_o          ( wb_o        )
        ,.watch_run_o   ( watch_run   )
    );

    bus_watchdog #(
        .TIMEOUT_CYCLES ( TIMEOUT_CYCLES )
    ) u_bus_watchdog (
         .clk_i     ( clk_i     )
        ,.rst_ni    ( rst_ni    )
        ,.run_i     ( watch_run )
        ,.timeout_o ( timeout   )
    );

endmodule

//--- tests/tb_clock.sv
`timescale 1ns/1ps
// ------------------------------
// Testbench clock and reset
// 40 ns clock, reset held low for two cycles
// ------------------------------
module tb_clock #(
    parameter int unsigned PERIOD_NS = 40
) (
     output logic clk_o
    ,output logic rst_no
);

    initial begin
        clk_o  = 1'b0;
        rst_no = 1'b0;
        repeat (2) @(posedge clk_o);
        rst_no <= 1'b1;
    end

    always #(PERIOD_NS / 2) clk_o = ~clk_o;

endmodule

//--- tests/bridge_monitor.sv
`timescale 1ns/1ps
// ------------------------------
// Bridge monitor
// Watches the port replies and compares them with the expected ones
// ------------------------------
module bridge_monitor (
     input  logic                  clk_i
    ,input  logic                  rst_ni
    ,input  logic                  fetch_valid_i
    ,input  logic                  lsu_valid_i
    ,input  bridge_pkg::wb_m2s_t   wb_m_i
    ,input  logic                  fetch_ack_i
    ,input  bridge_pkg::port_rsp_t fetch_rsp_i
    ,input  logic                  lsu_ack_i
    ,input  bridge_pkg::port_rsp_t lsu_rsp_i
    ,input  bridge_pkg::port_rsp_t exp_fetch_i
    ,input  bridge_pkg::port_rsp_t exp_lsu_i
    ,input  int                    test_id_i
    ,output int                    pass_cnt_o
    ,output int                    fail_cnt_o
);

    import bridge_pkg::*;

    logic idle_phase;
    logic idle_bad;

    initial begin
        pass_cnt_o = 0;
        fail_cnt_o = 0;
        idle_phase = 1'b1;
        idle_bad   = 1'b0;
    end

    task automatic compare_rsp(input string port, input port_rsp_t got, input port_rsp_t exp);
        if (got !== exp) begin
            $display("ERR %0t: test %0d %s got data %h err %b, expected data %h err %b",
                     $time, test_id_i, port, got.rdata, got.err, exp.rdata, exp.err);
            $display("test %0d %s: FAIL", test_id_i, port);
            fail_cnt_o++;
        end else begin
            $display("test %0d %s: pass", test_id_i, port);
            pass_cnt_o++;
        end
    endtask

    // Sampled mid-cycle, away from the driving edge
    always @(negedge clk_i) begin
        if (rst_ni && idle_phase) begin
            if (fetch_valid_i || lsu_valid_i) begin
                idle_phase = 1'b0;
                if (idle_bad) begin
                    $display("test 0 reset state: FAIL");
                    fail_cnt_o++;
                end else begin
                    $display("test 0 reset state: pass");
                    pass_cnt_o++;
                end
            end else if (wb_m_i.cyc || wb_m_i.stb || fetch_ack_i || lsu_ack_i) begin
                $display("ERR %0t: bus or port ack active before the first request", $time);
                idle_bad = 1'b1;
            end
        end

        // One bus cycle at a time, so never two acks together
        if (fetch_ack_i && lsu_ack_i) begin
            $display("ERR %0t: test %0d fetch and load/store acked together",
                     $time, test_id_i);
            fail_cnt_o++;
        end
        if (fetch_ack_i) begin
            compare_rsp("fetch", fetch_rsp_i, exp_fetch_i);
        end
        if (lsu_ack_i) begin
            compare_rsp("load/store", lsu_rsp_i, exp_lsu_i);
        end
    end

endmodule

//--- tests/bridge_checker.sv
`timescale 1ns/1ps
// ------------------------------
// Bridge checker
// Wishbone and port ack protocol assertions
// ------------------------------
module bridge_checker (
     input logic                clk_i
    ,input logic                rst_ni
    ,input bridge_pkg::wb_m2s_t wb_m_i
    ,input bridge_pkg::wb_s2m_t wb_s_i
    ,input logic                fetch_ack_i
    ,input logic                lsu_ack_i
);

    stb_matches_cyc: assert property (@(posedge clk_i) disable iff (!rst_ni)
        wb_m_i.stb == wb_m_i.cyc)
        else $error("stb differs from cyc");

    // Master side frozen while one cycle stays open
    master_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (wb_m_i.cyc && $past(wb_m_i.cyc)) |->
            $stable({wb_m_i.we, wb_m_i.adr, wb_m_i.dat, wb_m_i.sel}))
        else $error("master signals changed during an open cycle");

    // Classic cycle ends on the edge that samples the reply
    ends_on_reply: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (wb_m_i.cyc && (wb_s_i.ack || wb_s_i.err)) |=> !wb_m_i.cyc)
        else $error("cycle stayed open after the slave replied");

    ack_after_cycle: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (fetch_ack_i || lsu_ack_i) |-> ($past(wb_m_i.cyc) && !wb_m_i.cyc))
        else $error("port ack without a preceding bus cycle");

endmodule

bind core_bus_bridge bridge_checker u_checker (
     .clk_i       ( clk_i       )
    ,.rst_ni      ( rst_ni      )
    ,.wb_m_i      ( wb_o        )
    ,.wb_s_i      ( wb_i        )
    ,.fetch_ack_i ( fetch_ack_o )
    ,.lsu_ack_i   ( lsu_ack_o   )
);

//--- tests/tb_top.sv
`timescale 1ns/1ps
// ------------------------------
// Bridge testbench
// Drives both core ports from the vector file against a
// Wishbone slave memory with random wait states
// ------------------------------
module tb_top;

    import bridge_pkg::*;

    localparam int ACK_TIMEOUT = 200;
    localparam int VEC_WORDS   = 7;
    localparam int MAX_VECS    = 32;

    logic       clk_i;
    logic       rst_n;
    logic       fetch_valid;
    fetch_req_t fetch_req;
    logic       lsu_valid;
    lsu_req_t   lsu_req;
    logic       fetch_ack;
    logic       lsu_ack;
    port_rsp_t  fetch_rsp;
    port_rsp_t  lsu_rsp;
    wb_m2s_t    wb_m;
    wb_s2m_t    wb_s;
    port_rsp_t  exp_fetch;
    port_rsp_t  exp_lsu;
    int         test_id;
    int         pass_cnt;
    int         fail_cnt;
    int         hang_cnt;
    logic [31:0] vec_mem [0:VEC_WORDS*MAX_VECS-1];

    tb_clock #(.PERIOD_NS(40)) u_clock (.clk_o(clk_i), .rst_no(rst_n));

    core_bus_bridge #(
        .TIMEOUT_CYCLES ( 16 )
    ) u_dut (
         .clk_i         ( clk_i       )
        ,.rst_ni        ( rst_n       )
        ,.fetch_valid_i ( fetch_valid )
        ,.fetch_req_i   ( fetch_req   )
        ,.lsu_valid_i   ( lsu_valid   )
        ,.lsu_req_i     ( lsu_req     )
        ,.wb_i          ( wb_s        )
        ,.fetch_ack_o   ( fetch_ack   )
        ,.fetch_rsp_o   ( fetch_rsp   )
        ,.lsu_ack_o     ( lsu_ack     )
        ,.lsu_rsp_o     ( lsu_rsp     )
        ,.wb_o          ( wb_m        )
    );

    bridge_monitor u_monitor (
         .clk_i         ( clk_i       )
        ,.rst_ni        ( rst_n       )
        ,.fetch_valid_i ( fetch_valid )
        ,.lsu_valid_i   ( lsu_valid   )
        ,.wb_m_i        ( wb_m        )
        ,.fetch_ack_i   ( fetch_ack   )
        ,.fetch_rsp_i   ( fetch_rsp   )
        ,.lsu_ack_i     ( lsu_ack     )
        ,.lsu_rsp_i     ( lsu_rsp     )
        ,.exp_fetch_i   ( exp_fetch   )
        ,.exp_lsu_i     ( exp_lsu     )
        ,.test_id_i     ( test_id     )
        ,.pass_cnt_o    ( pass_cnt    )
        ,.fail_cnt_o    ( fail_cnt    )
    );

    // ------------------------------
    // Wishbone slave model
    // ------------------------------
    logic [31:0] mem [0:255];
    logic        busy;
    logic [1:0]  wait_left;
    logic [31:0] lfsr_q;

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    initial begin
        logic [7:0] a;
        lfsr_q    = 32'd78778;
        busy      = 1'b0;
        wait_left = 2'd0;
        wb_s      = '0;
        // Every byte of the fill depends on the word index
        for (int i = 0; i < 256; i++) begin
            a      = i[7:0];
            mem[i] = {a, ~a, a ^ 8'h5A, a ^ 8'hC3};
        end
    end

    always @(posedge clk_i) begin
        logic       w0;
        logic [3:0] region;
        logic [7:0] idx;
        region    = wb_m.adr[31:28];
        idx       = wb_m.adr[9:2];
        wb_s.ack <= 1'b0;
        wb_s.err <= 1'b0;
        if (!wb_m.cyc) begin
            busy <= 1'b0;
        end else if (wb_m.stb && !wb_s.ack && !wb_s.err) begin
            if (!busy) begin
                // Two LFSR bits give 0 to 3 wait states
                lfsr_q     = lfsr_step(lfsr_q);
                w0         = lfsr_q[0];
                lfsr_q     = lfsr_step(lfsr_q);
                busy      <= 1'b1;
                wait_left <= {lfsr_q[0], w0};
            end else if (wait_left != 2'd0) begin
                wait_left <= wait_left - 2'd1;
            end else if (region == 4'hE) begin
                wb_s.err <= 1'b1;
                wb_s.dat <= '0;
                busy     <= 1'b0;
            end else if (region != 4'hF) begin
                wb_s.ack <= 1'b1;
                busy     <= 1'b0;
                if (wb_m.we) begin
                    wb_s.dat <= '0;
                    for (int b = 0; b < 4; b++) begin
                        if (wb_m.sel[b]) begin
                            mem[idx][8*b +: 8] <= wb_m.dat[8*b +: 8];
                        end
                    end
                end else begin
                    wb_s.dat <= mem[idx];
                end
            end
        end
    end

    // ------------------------------
    // Stimulus
    // ------------------------------
    task automatic wait_acks(input logic need_f, input logic need_l);
        int   n;
        logic got_f;
        logic got_l;
        n     = 0;
        got_f = ~need_f;
        got_l = ~need_l;
        while (!(got_f && got_l) && n < ACK_TIMEOUT) begin
            @(negedge clk_i);
            if (fetch_ack) got_f = 1'b1;
            if (lsu_ack) begin
                got_l = 1'b1;
                // Core drops its held request once acked
                @(posedge clk_i);
                lsu_valid <= 1'b0;
            end
            n++;
        end
        if (!(got_f && got_l)) begin
            $display("Test %0d timed out: no ack within %0d cycles", test_id, ACK_TIMEOUT);
            hang_cnt++;
        end
    endtask

    task automatic run_vector(input int idx, input logic [31:0] kind, input logic [31:0] addr,
                              input logic [31:0] data, input logic [31:0] sel,
                              input logic [31:0] exp_d, input logic [31:0] exp_e,
                              input logic [31:0] exp_d2);
        logic use_f;
        logic use_l;
        use_f = (kind == 32'd1) || (kind == 32'd4);
        use_l = (kind != 32'd1);
        @(posedge clk_i);
        test_id   <= idx;
        exp_fetch <= '{rdata: exp_d, err: exp_e[0]};
        exp_lsu   <= '{rdata: (kind == 32'd4) ? exp_d2 : exp_d, err: exp_e[0]};
        if (use_f) begin
            fetch_valid <= 1'b1;
            fetch_req   <= '{addr: addr};
        end
        if (use_l) begin
            lsu_valid <= 1'b1;
            lsu_req   <= '{we: (kind == 32'd3), addr: (kind == 32'd4) ? data : addr,
                           wdata: data, sel: (kind == 32'd4) ? 4'hF : sel[3:0]};
        end
        @(posedge clk_i);
        fetch_valid <= 1'b0;
        wait_acks(use_f, use_l);
        @(posedge clk_i);
        lsu_valid <= 1'b0;
    endtask

    initial begin
        int n;
        int base;
        fetch_valid = 1'b0;
        fetch_req   = '0;
        lsu_valid   = 1'b0;
        lsu_req     = '0;
        exp_fetch   = '0;
        exp_lsu     = '0;
        test_id     = 0;
        hang_cnt    = 0;
        for (int i = 0; i < VEC_WORDS * MAX_VECS; i++) begin
            vec_mem[i] = '0;
        end
        $readmemh("tests/bridge_testdata.txt", vec_mem);

        n = 0;
        while (!rst_n && n < 10) begin
            @(posedge clk_i);
            n++;
        end
        if (!rst_n) begin
            $display("Reset never released");
            hang_cnt++;
        end
        // Quiet stretch for the reset state check
        repeat (4) @(posedge clk_i);

        for (int v = 0; v < MAX_VECS; v++) begin
            base = v * VEC_WORDS;
            if (vec_mem[base] == 32'd0 || vec_mem[base] > 32'd4) break;
            run_vector(v + 1, vec_mem[base], vec_mem[base+1], vec_mem[base+2],
                       vec_mem[base+3], vec_mem[base+4], vec_mem[base+5],
                       vec_mem[base+6]);
        end

        repeat (2) @(posedge clk_i);
        $display("Passed %0d, failed %0d, timed out %0d", pass_cnt, fail_cnt, hang_cnt);
        if (fail_cnt == 0 && hang_cnt == 0 && pass_cnt > 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

//--- tests/bridge_testdata.txt
// kind addr data sel exp_data exp_err exp_data2 (all hex)
// kind 1 fetch, 2 load, 3 store, 4 fetch and load together with data as load address
1 00000010 00000000 0 04FB5EC7 0 00000000
2 00000020 00000000 F 08F752CB 0 00000000
1 00000014 00000000 0 05FA5FC6 0 00000000
// Partial stores then read-back
3 00000040 AABBCCDD 5 00000000 0 00000000
2 00000040 00000000 F 10BB4ADD 0 00000000
3 00000014 99887766 A 00000000 0 00000000
2 00000014 00000000 F 99FA77C6 0 00000000
3 00000080 12345678 F 00000000 0 00000000
1 00000080 00000000 0 12345678 0 00000000
// Both ports in the same cycle
4 00000020 0000000C 0 08F752CB 0 03FC59C0
4 00000040 00000010 0 10BB4ADD 0 04FB5EC7
4 00000080 00000014 0 12345678 0 99FA77C6
// Error region
2 E0000000 00000000 F 00000000 1 00000000
1 E0000004 00000000 0 00000000 1 00000000
3 E0000008 11111111 F 00000000 1 00000000
// Silent region, ended by the watchdog
2 F0000000 00000000 F 00000000 1 00000000
1 F0000008 00000000 0 00000000 1 00000000
3 F000000C 22222222 3 00000000 1 00000000
// Bus still usable afterwards
4 00000010 00000020 0 04FB5EC7 0 08F752CB

//--- project.f
logic/bridge_pkg.sv
logic/fetch_port.sv
logic/lsu_port.sv
logic/bus_cycle_fsm.sv
logic/bus_watchdog.sv
logic/core_bus_bridge.sv
tests/tb_clock.sv
tests/bridge_monitor.sv
tests/bridge_checker.sv
tests/tb_top.sv

//--- Makefile
# Verilator build and run for the core bus bridge

VERILATOR ?= verilator
TOP       ?= tb_top
OBJ_DIR   ?= obj_dir
FILELIST  ?= project.f
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Everything OK

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$($(abspath $(BIN)))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
